// File: verilog/rv32Pkg.sv
// RV32I widths, opcode encodings and instruction word formats
// ALU operation and class codes
package rv32Pkg;

	localparam int xlen = 32;
	localparam int regAdrW = 5;
	localparam int regCount = 1 << regAdrW;

	// funct3 codes of the implemented subset
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3Beq = 3'b000;

	typedef enum logic [6:0] {
		rType = 7'b0110011,
		iTypeAlu = 7'b0010011,
		iTypeLoad = 7'b0000011,
		sType = 7'b0100011,
		bType = 7'b1100011,
		jType = 7'b1101111
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [regAdrW-1:0] rs2;
		logic [regAdrW-1:0] rs1;
		logic [2:0] funct3;
		logic [regAdrW-1:0] rd;
		opcode_t opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [regAdrW-1:0] rs1;
		logic [2:0] funct3;
		logic [regAdrW-1:0] rd;
		opcode_t opcode;
	} iFmt_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [regAdrW-1:0] rs2;
		logic [regAdrW-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcode_t opcode;
	} sFmt_t;

	// branch offset is scattered, bit 0 implied zero
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [regAdrW-1:0] rs2;
		logic [regAdrW-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		opcode_t opcode;
	} bFmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [regAdrW-1:0] rd;
		opcode_t opcode;
	} jFmt_t;

	// one instruction word, one view per format
	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		sFmt_t sFmt;
		bFmt_t bFmt;
		jFmt_t jFmt;
	} instr_u;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt
	} aluOp_t;

	// add for addresses and pc math, sub for beq, funct for ALU instructions
	typedef enum logic [1:0] {
		classAdd,
		classSub,
		classFunct
	} aluClass_t;

endpackage

// File: verilog/coreCtrlPkg.sv
// FSM states, datapath selects, control struct and APB request struct
package coreCtrlPkg;

	import rv32Pkg::*;

	typedef enum logic [3:0] {
		fetchSetup,
		fetchAccess,
		decode,
		executeR,
		executeI,
		jump,
		memAdr,
		memSetup,
		memAccess,
		aluWb,
		memWb,
		branchEq,
		trap
	} state_t;

	typedef enum logic [1:0] {
		srcPc,
		srcOldPc,
		srcRs1
	} srcA_t;

	typedef enum logic [1:0] {
		srcRs2,
		srcImm,
		srcFour
	} srcB_t;

	typedef enum logic [1:0] {
		resAluOut,
		resData,
		resAlu
	} resultSrc_t;

	typedef enum logic {
		adrPc,
		adrResult
	} adrSrc_t;

	typedef struct packed {
		logic irWrite;
		logic regWrite;
		logic pcUpdate;
		logic pcJump;
		srcA_t srcA;
		srcB_t srcB;
		aluClass_t aluClass;
		resultSrc_t resultSrc;
		adrSrc_t adrSrc;
		logic dataWrite;
	} ctrl_t;

	// master side of the APB port
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [xlen-1:0] paddr;
		logic [xlen-1:0] pwdata;
	} apbReq_t;

endpackage

// File: verilog/controlFsm.sv
// Moore control FSM for instruction sequencing and APB transfer phases
`timescale 1ns/1ns

module controlFsm import rv32Pkg::*, coreCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input opcode_t opcode,
	input logic [2:0] funct3,
	input logic zero,
	input logic pready,
	input logic pslverr,
	output ctrl_t ctrl,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic trap,
	output state_t state
);

	state_t nextState;
	logic running;
	logic aluFunctOk;

	// funct3 values the ALU implements
	assign aluFunctOk = funct3 inside {f3AddSub, f3Slt, f3Xor, f3Or, f3And};

	// running holds off the first setup phase until reset has been released
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetchSetup;
			running <= 1'b0;
		end else begin
			state <= nextState;
			running <= 1'b1;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			fetchSetup: begin
				if (running)
					nextState = fetchAccess;
			end
			fetchAccess: begin
				if (pready)
					nextState = pslverr ? coreCtrlPkg::trap : decode;
			end
			decode: begin
				case (opcode)
					rType: nextState = aluFunctOk ? executeR : coreCtrlPkg::trap;
					iTypeAlu: nextState = aluFunctOk ? executeI : coreCtrlPkg::trap;
					iTypeLoad: nextState = (funct3 == f3Word) ? memAdr : coreCtrlPkg::trap;
					sType: nextState = (funct3 == f3Word) ? memSetup : coreCtrlPkg::trap;
					bType: nextState = (funct3 == f3Beq) ? branchEq : coreCtrlPkg::trap;
					jType: nextState = jump;
					default: nextState = coreCtrlPkg::trap;
				endcase
			end
			executeR, executeI, jump: nextState = aluWb;
			memAdr, memSetup: nextState = memAccess;
			memAccess: begin
				if (pready) begin
					if (pslverr)
						nextState = coreCtrlPkg::trap;
					else if (opcode == iTypeLoad)
						nextState = memWb;
					else
						nextState = fetchSetup;
				end
			end
			aluWb, memWb, branchEq: nextState = fetchSetup;
			coreCtrlPkg::trap: nextState = coreCtrlPkg::trap;
			default: nextState = coreCtrlPkg::trap;
		endcase
	end

	always_comb begin
		ctrl = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		trap = 1'b0;
		case (state)
			fetchSetup: begin
				ctrl.adrSrc = adrPc;
				psel = running;
			end
			// pc and IR move only in the completion cycle
			fetchAccess: begin
				ctrl.adrSrc = adrPc;
				ctrl.irWrite = pready;
				ctrl.pcUpdate = pready;
				psel = 1'b1;
				penable = 1'b1;
			end
			// jump and branch target into ALU-out
			decode: begin
				ctrl.srcA = srcOldPc;
				ctrl.srcB = srcImm;
				ctrl.aluClass = classAdd;
			end
			executeR: begin
				ctrl.srcA = srcRs1;
				ctrl.srcB = srcRs2;
				ctrl.aluClass = classFunct;
			end
			executeI: begin
				ctrl.srcA = srcRs1;
				ctrl.srcB = srcImm;
				ctrl.aluClass = classFunct;
			end
			// load target from ALU-out, link computed alongside
			jump: begin
				ctrl.srcA = srcOldPc;
				ctrl.srcB = srcFour;
				ctrl.aluClass = classAdd;
				ctrl.resultSrc = resAluOut;
				ctrl.pcUpdate = 1'b1;
				ctrl.pcJump = 1'b1;
			end
			// setup phase, address straight from the ALU
			memAdr, memSetup: begin
				ctrl.srcA = srcRs1;
				ctrl.srcB = srcImm;
				ctrl.aluClass = classAdd;
				ctrl.resultSrc = resAlu;
				ctrl.adrSrc = adrResult;
				psel = 1'b1;
				pwrite = (state == memSetup);
			end
			// ALU keeps rs1 + imm so ALU-out holds the address
			memAccess: begin
				ctrl.srcA = srcRs1;
				ctrl.srcB = srcImm;
				ctrl.aluClass = classAdd;
				ctrl.resultSrc = resAluOut;
				ctrl.adrSrc = adrResult;
				ctrl.dataWrite = (opcode == iTypeLoad);
				psel = 1'b1;
				penable = 1'b1;
				pwrite = (opcode == sType);
			end
			aluWb: begin
				ctrl.resultSrc = resAluOut;
				ctrl.regWrite = 1'b1;
			end
			memWb: begin
				ctrl.resultSrc = resData;
				ctrl.regWrite = 1'b1;
			end
			// pc was already advanced in fetch, so only a taken branch updates it
			branchEq: begin
				ctrl.srcA = srcRs1;
				ctrl.srcB = srcRs2;
				ctrl.aluClass = classSub;
				ctrl.resultSrc = resAluOut;
				ctrl.pcUpdate = zero;
				ctrl.pcJump = zero;
			end
			coreCtrlPkg::trap: trap = 1'b1;
			default: trap = 1'b0;
		endcase
	end

	// access phase always preceded by a setup or access cycle of the same transfer
	apbAccessAfterSetup: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel && $past(psel));

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state inside {[fetchSetup:coreCtrlPkg::trap]});

endmodule

// File: verilog/programCounter.sv
// program counter and old-PC register
`timescale 1ns/1ns

module programCounter import rv32Pkg::*, coreCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input logic [xlen-1:0] target,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] oldPc
);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			oldPc <= '0;
		end else begin
			if (ctrl.pcUpdate)
				pc <= ctrl.pcJump ? target : pc + xlen'(4);
			// address of the instruction just fetched
			if (ctrl.irWrite)
				oldPc <= pc;
		end
	end

	// jump targets from the datapath keep word alignment
	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: verilog/registerFile.sv
// 32-entry register file, two read ports and one write port
`timescale 1ns/1ns

module registerFile import rv32Pkg::*; (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [regAdrW-1:0] ra1,
	input logic [regAdrW-1:0] ra2,
	input logic [regAdrW-1:0] wa,
	input logic [xlen-1:0] wd,
	output logic [xlen-1:0] rd1,
	output logic [xlen-1:0] rd2
);

	logic [xlen-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads as zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: verilog/execDatapath.sv
// datapath with instruction and data registers, immediates, ALU, ALU-out
// and the result and address muxes
`timescale 1ns/1ns

module execDatapath import rv32Pkg::*, coreCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input logic [xlen-1:0] prdata,
	input logic pready,
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] oldPc,
	input logic [xlen-1:0] rd1,
	input logic [xlen-1:0] rd2,
	output instr_u instr,
	output logic [xlen-1:0] paddr,
	output logic [xlen-1:0] pwdata,
	output logic [xlen-1:0] result,
	output logic zero
);

	logic [xlen-1:0] dataReg;
	logic [xlen-1:0] aluOut;
	logic [xlen-1:0] immExt;
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluResult;
	aluOp_t aluOp;

	// instruction register, loaded when a fetch completes
	always_ff @(posedge clk) begin
		if (reset)
			instr <= '0;
		else if (ctrl.irWrite)
			instr <= prdata;
	end

	always_ff @(posedge clk) begin
		if (ctrl.dataWrite && pready)
			dataReg <= prdata;
		aluOut <= aluResult;
	end

	// immediate by format
	always_comb begin
		case (instr.rFmt.opcode)
			sType: immExt = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
			bType: immExt = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
				instr.bFmt.imm10to5, instr.bFmt.imm4to1, 1'b0};
			jType: immExt = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.imm19to12,
				instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
			default: immExt = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
		endcase
	end

	// ALU decoder; funct7 only matters for R-type sub
	always_comb begin
		case (ctrl.aluClass)
			classAdd: aluOp = aluAdd;
			classSub: aluOp = aluSub;
			default: begin
				case (instr.rFmt.funct3)
					f3AddSub: begin
						if (instr.rFmt.opcode == rType && instr.rFmt.funct7[5])
							aluOp = aluSub;
						else
							aluOp = aluAdd;
					end
					f3Slt: aluOp = aluSlt;
					f3Xor: aluOp = aluXor;
					f3Or: aluOp = aluOr;
					f3And: aluOp = aluAnd;
					default: aluOp = aluAdd;
				endcase
			end
		endcase
	end

	always_comb begin
		case (ctrl.srcA)
			srcPc: opA = pc;
			srcOldPc: opA = oldPc;
			default: opA = rd1;
		endcase
		case (ctrl.srcB)
			srcRs2: opB = rd2;
			srcImm: opB = immExt;
			default: opB = xlen'(4);
		endcase
	end

	always_comb begin
		case (aluOp)
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluSlt: aluResult = {{(xlen - 1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	assign zero = (aluResult == '0);

	always_comb begin
		case (ctrl.resultSrc)
			resData: result = dataReg;
			resAlu: result = aluResult;
			default: result = aluOut;
		endcase
	end

	assign paddr = (ctrl.adrSrc == adrPc) ? pc : result;
	// store data, rs2 read straight from the register file
	assign pwdata = rd2;

endmodule

// File: verilog/multicycleCore.sv
// multicycle RV32I core top with FSM, program counter, register file and datapath
`timescale 1ns/1ns

module multicycleCore import rv32Pkg::*, coreCtrlPkg::*; (
	input logic clk,
	input logic reset,
	input logic [xlen-1:0] prdata,
	input logic pready,
	input logic pslverr,
	output apbReq_t apb,
	output logic trap
);

	ctrl_t ctrl;
	instr_u instr;
	logic zero;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] oldPc;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] result;

	// APB control phases from the FSM
	controlFsm u_controlFsm (
		.clk(clk),
		.reset(reset),
		.opcode(instr.rFmt.opcode),
		.funct3(instr.rFmt.funct3),
		.zero(zero),
		.pready(pready),
		.pslverr(pslverr),
		.ctrl(ctrl),
		.psel(apb.psel),
		.penable(apb.penable),
		.pwrite(apb.pwrite),
		.trap(trap),
		.state()
	);

	programCounter u_programCounter (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.target(result),
		.pc(pc),
		.oldPc(oldPc)
	);

	registerFile u_registerFile (
		.clk(clk),
		.reset(reset),
		.we(ctrl.regWrite),
		.ra1(instr.rFmt.rs1),
		.ra2(instr.rFmt.rs2),
		.wa(instr.rFmt.rd),
		.wd(result),
		.rd1(rd1),
		.rd2(rd2)
	);

	// address and write data of the APB port
	execDatapath u_execDatapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.prdata(prdata),
		.pready(pready),
		.pc(pc),
		.oldPc(oldPc),
		.rd1(rd1),
		.rd2(rd2),
		.instr(instr),
		.paddr(apb.paddr),
		.pwdata(apb.pwdata),
		.result(result),
		.zero(zero)
	);

endmodule

// File: dv/tbClock.sv
// free-running testbench clock, 100 ns period
`timescale 1ns/1ns

module tbClock (
	output logic clk
);

	localparam int periodNs = 100;

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

endmodule

// File: dv/apbMemory.sv
// APB slave memory model with seeded random wait states and
// an optional slave error on one address
`timescale 1ns/1ns

module apbMemory import coreCtrlPkg::*; (
	input logic clk,
	input apbReq_t apb,
	input logic useWaits,
	input logic errEnable,
	input logic [31:0] errAdr,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	localparam int memWords = 1024;

	// word storage, loaded directly by the testbench
	logic [31:0] mem [memWords];
	integer seed;
	int waitLeft;

	initial begin
		seed = 32'h6149;
		waitLeft = 0;
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;
	end

	// responses change on the falling edge, core samples on the rising edge
	always @(negedge clk) begin
		pready <= 1'b0;
		pslverr <= 1'b0;
		if (apb.psel && !apb.penable) begin
			// wait cycles for the transfer that starts here
			waitLeft = useWaits ? ($unsigned($random(seed)) % 4) : 0;
		end else if (apb.psel && apb.penable) begin
			if (waitLeft > 0) begin
				waitLeft--;
			end else begin
				pready <= 1'b1;
				if (errEnable && apb.paddr == errAdr)
					pslverr <= 1'b1;
				else if (apb.pwrite)
					mem[apb.paddr[11:2]] = apb.pwdata;
				prdata <= mem[apb.paddr[11:2]];
			end
		end
	end

endmodule

// File: dv/coreTb.sv
// testbench top with core, APB memory model, bus monitor, directed tests
// and watchdog
`timescale 1ns/1ns

module coreTb import rv32Pkg::*, coreCtrlPkg::*; ();

	localparam int clkPeriodNs = 100;
	localparam int resetCycles = 10;
	localparam int memWords = 1024;
	// instructions over all programs, trap words included
	localparam int instrTotal = 79;
	// lw with 3 waits on both the fetch and the data transfer
	localparam int worstCpi = 12;
	// reset, idle watch after trap and slack, per program run
	localparam int runOverhead = 40;
	localparam int programRuns = 7;
	localparam int watchdogNs = (instrTotal * worstCpi + programRuns * runOverhead + 100)
		* clkPeriodNs;

	logic clk;
	logic reset;
	logic useWaits;
	logic errEnable;
	logic [xlen-1:0] errAdr;
	logic [xlen-1:0] prdata;
	logic pready;
	logic pslverr;
	logic trap;
	apbReq_t apb;

	logic [xlen-1:0] asmAdr;
	logic [xlen-1:0] refImage [memWords];
	logic [xlen-1:0] holdAdr;
	logic [xlen-1:0] holdData;
	logic holdWrite;
	logic resetHeld;
	int sinceReset;
	int xferCount;
	int stallCount;

	tbClock clkGen (
		.clk(clk)
	);

	apbMemory memModel (
		.clk(clk),
		.apb(apb),
		.useWaits(useWaits),
		.errEnable(errEnable),
		.errAdr(errAdr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	multicycleCore u_multicycleCore (
		.clk(clk),
		.reset(reset),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.apb(apb),
		.trap(trap)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, actual, expected));
	endtask

	function automatic logic [31:0] fillWord(input logic [31:0] adr);
		return 32'ha5a50000 ^ adr;
	endfunction

	function automatic logic [31:0] peekWord(input logic [31:0] adr);
		return memModel.mem[adr[11:2]];
	endfunction

	task automatic pokeWord(input logic [31:0] adr, input logic [31:0] data);
		memModel.mem[adr[11:2]] = data;
	endtask

	// instruction assembly, RV32I encodings
	task automatic emit(input logic [31:0] word);
		memModel.mem[asmAdr[11:2]] = word;
		asmAdr = asmAdr + 32'd4;
	endtask

	task automatic emitR(input logic [6:0] funct7, input logic [2:0] funct3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		emit({funct7, rs2, rs1, funct3, rd, rType});
	endtask

	task automatic emitAluI(input logic [2:0] funct3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		emit({imm, rs1, funct3, rd, iTypeAlu});
	endtask

	task automatic emitLoad(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		emit({imm, rs1, 3'b010, rd, iTypeLoad});
	endtask

	task automatic emitStore(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], sType});
	endtask

	task automatic emitBeq(input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] off);
		emit({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], bType});
	endtask

	task automatic emitJal(input logic [4:0] rd, input logic [20:0] off);
		emit({off[20], off[10:1], off[11], off[19:12], rd, jType});
	endtask

	// opcode 7'h7f is outside the implemented set
	task automatic emitIllegal();
		emit(32'hffffffff);
	endtask

	// bus monitor for quiet bus in reset, first fetch and APB hold rules
	always @(posedge clk) begin
		if (apb.penable && !apb.psel)
			abortRun("APB penable was high while psel was low");
		if (reset) begin
			if (resetHeld) begin
				checkValue("psel", apb.psel, 1'b0);
				checkValue("penable", apb.penable, 1'b0);
			end
			resetHeld = 1'b1;
			sinceReset = 0;
			xferCount = 0;
		end else begin
			resetHeld = 1'b0;
			sinceReset++;
			// setup of the first fetch in the second cycle after release
			if (sinceReset == 2) begin
				checkValue("psel", apb.psel, 1'b1);
				checkValue("paddr", apb.paddr, 32'h0);
				checkValue("pwrite", apb.pwrite, 1'b0);
			end
			if (apb.psel && !apb.penable) begin
				holdAdr = apb.paddr;
				holdWrite = apb.pwrite;
				holdData = apb.pwdata;
				xferCount++;
			end else if (apb.psel && apb.penable) begin
				checkValue("paddr", apb.paddr, holdAdr);
				checkValue("pwrite", apb.pwrite, holdWrite);
				if (holdWrite)
					checkValue("pwdata", apb.pwdata, holdData);
				if (!pready)
					stallCount++;
			end
		end
	end

	task automatic beginProgram(input logic withWaits);
		@(negedge clk);
		reset = 1'b1;
		useWaits = withWaits;
		errEnable = 1'b0;
		for (int i = 0; i < memWords; i++)
			memModel.mem[i] = fillWord(32'(i) << 2);
		asmAdr = '0;
	endtask

	task automatic runProgram();
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		while (trap !== 1'b1)
			@(negedge clk);
	endtask

	task automatic watchIdle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			checkValue("psel", apb.psel, 1'b0);
			checkValue("trap", trap, 1'b1);
		end
	endtask

	task automatic resetFetchTest();
		beginProgram(1'b0);
		emitIllegal();
		runProgram();
		checkValue("transfer count", xferCount, 32'd1);
	endtask

	task automatic arithmeticTest();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] want [12];
		a = 32'd100;
		b = -32'sd7;
		want[0] = a + b;
		want[1] = a - b;
		want[2] = a & b;
		want[3] = a | b;
		want[4] = a ^ b;
		want[5] = {31'b0, $signed(b) < $signed(a)};
		want[6] = {31'b0, $signed(a) < $signed(b)};
		want[7] = a & 32'h0f0;
		want[8] = b | 32'h123;
		want[9] = a ^ 32'hffffffff;
		want[10] = {31'b0, $signed(b) < -32'sd6};
		want[11] = a + 32'hfffff800;
		beginProgram(1'b0);
		emitAluI(f3AddSub, 5'd1, 5'd0, 12'd100);
		emitAluI(f3AddSub, 5'd2, 5'd0, -12'sd7);
		emitR(7'h00, f3AddSub, 5'd3, 5'd1, 5'd2);
		emitR(7'h20, f3AddSub, 5'd4, 5'd1, 5'd2);
		emitR(7'h00, f3And, 5'd5, 5'd1, 5'd2);
		emitR(7'h00, f3Or, 5'd6, 5'd1, 5'd2);
		emitR(7'h00, f3Xor, 5'd7, 5'd1, 5'd2);
		emitR(7'h00, f3Slt, 5'd8, 5'd2, 5'd1);
		emitR(7'h00, f3Slt, 5'd9, 5'd1, 5'd2);
		emitAluI(f3And, 5'd10, 5'd1, 12'h0f0);
		emitAluI(f3Or, 5'd11, 5'd2, 12'h123);
		emitAluI(f3Xor, 5'd12, 5'd1, -12'sd1);
		emitAluI(f3Slt, 5'd13, 5'd2, -12'sd6);
		// addi with -2048
		emitAluI(f3AddSub, 5'd14, 5'd1, 12'h800);
		emitR(7'h00, f3AddSub, 5'd0, 5'd1, 5'd1);
		for (int r = 3; r <= 14; r++)
			emitStore(5'(r), 5'd0, 12'(12'h400 + 4 * (r - 3)));
		emitStore(5'd0, 5'd0, 12'h430);
		emitIllegal();
		runProgram();
		for (int r = 3; r <= 14; r++)
			checkValue($sformatf("x%0d stored", r), peekWord(32'h400 + 32'(4 * (r - 3))),
				want[r-3]);
		checkValue("x0 stored", peekWord(32'h430), 32'h0);
	endtask

	task automatic loadStoreTest(input logic withWaits);
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] d2;
		d0 = 32'h12345678;
		d1 = 32'hfffffff0;
		d2 = 32'h7fffffff;
		beginProgram(withWaits);
		pokeWord(32'h500, d0);
		pokeWord(32'h504, d1);
		pokeWord(32'h508, d2);
		emitAluI(f3AddSub, 5'd4, 5'd0, 12'h500);
		emitLoad(5'd1, 5'd4, 12'd0);
		emitLoad(5'd2, 5'd4, 12'd4);
		emitLoad(5'd3, 5'd4, 12'd8);
		emitAluI(f3AddSub, 5'd1, 5'd1, 12'd1);
		emitAluI(f3AddSub, 5'd2, 5'd2, -12'sd16);
		emitAluI(f3AddSub, 5'd3, 5'd3, 12'd1);
		emitStore(5'd1, 5'd4, 12'h100);
		emitStore(5'd2, 5'd4, 12'h104);
		emitStore(5'd3, 5'd4, 12'h108);
		emitAluI(f3AddSub, 5'd5, 5'd0, 12'h620);
		emitStore(5'd1, 5'd5, -12'sd4);
		// 0x620 - 284 reaches back to 0x504
		emitLoad(5'd6, 5'd5, -12'sd284);
		emitStore(5'd6, 5'd4, 12'h10c);
		emitIllegal();
		runProgram();
		checkValue("mem[600]", peekWord(32'h600), d0 + 32'd1);
		checkValue("mem[604]", peekWord(32'h604), d1 - 32'd16);
		checkValue("mem[608]", peekWord(32'h608), d2 + 32'd1);
		checkValue("mem[60c]", peekWord(32'h60c), d1);
		checkValue("mem[61c]", peekWord(32'h61c), d0 + 32'd1);
		checkValue("mem[500]", peekWord(32'h500), d0);
		if (!withWaits) begin
			for (int i = 0; i < memWords; i++)
				refImage[i] = memModel.mem[i];
		end
	endtask

	task automatic branchJumpTest();
		logic [31:0] jalAdr;
		beginProgram(1'b0);
		emitAluI(f3AddSub, 5'd1, 5'd0, 12'd5);
		emitAluI(f3AddSub, 5'd2, 5'd0, 12'd5);
		emitAluI(f3AddSub, 5'd3, 5'd0, 12'd7);
		emitAluI(f3AddSub, 5'd9, 5'd0, 12'h055);
		// taken, skips the marker store
		emitBeq(5'd1, 5'd2, 13'd8);
		emitStore(5'd9, 5'd0, 12'h700);
		emitBeq(5'd1, 5'd3, 13'd8);
		emitStore(5'd9, 5'd0, 12'h704);
		jalAdr = asmAdr;
		emitJal(5'd5, 21'd8);
		emitStore(5'd9, 5'd0, 12'h708);
		emitStore(5'd5, 5'd0, 12'h70c);
		emitIllegal();
		runProgram();
		checkValue("mem[700]", peekWord(32'h700), fillWord(32'h700));
		checkValue("mem[704]", peekWord(32'h704), 32'h55);
		checkValue("mem[708]", peekWord(32'h708), fillWord(32'h708));
		checkValue("jal link", peekWord(32'h70c), jalAdr + 32'd4);
	endtask

	task automatic backPressureTest();
		int stallsBefore;
		stallsBefore = stallCount;
		loadStoreTest(1'b1);
		if (stallCount == stallsBefore)
			abortRun("no wait states were inserted during the back-pressure run");
		for (int i = 0; i < memWords; i++)
			checkValue($sformatf("mem[%h]", i * 4), memModel.mem[i], refImage[i]);
	endtask

	task automatic trapTest();
		// illegal opcode, store behind it never runs
		beginProgram(1'b0);
		emitAluI(f3AddSub, 5'd1, 5'd0, 12'd3);
		emitStore(5'd1, 5'd0, 12'h400);
		emitIllegal();
		emitStore(5'd1, 5'd0, 12'h404);
		runProgram();
		checkValue("mem[400]", peekWord(32'h400), 32'd3);
		checkValue("mem[404]", peekWord(32'h404), fillWord(32'h404));
		watchIdle(20);
		// slave error on the third fetch
		beginProgram(1'b0);
		errEnable = 1'b1;
		errAdr = 32'h8;
		emitAluI(f3AddSub, 5'd1, 5'd0, 12'd9);
		emitStore(5'd1, 5'd0, 12'h404);
		emitStore(5'd1, 5'd0, 12'h408);
		runProgram();
		checkValue("mem[404]", peekWord(32'h404), 32'd9);
		checkValue("mem[408]", peekWord(32'h408), fillWord(32'h408));
		watchIdle(20);
	endtask

	initial begin
		reset = 1'b1;
		useWaits = 1'b0;
		errEnable = 1'b0;
		errAdr = '0;
		asmAdr = '0;
		resetHeld = 1'b0;
		sinceReset = 0;
		xferCount = 0;
		stallCount = 0;
		resetFetchTest();
		arithmeticTest();
		loadStoreTest(1'b0);
		branchJumpTest();
		backPressureTest();
		trapTest();
		$display("Test completed successfully");
		$finish;
	end

	initial begin
		#(watchdogNs);
		abortRun($sformatf("watchdog expired after %0d ns before the tests finished",
			watchdogNs));
	end

endmodule

// File: project.f
verilog/rv32Pkg.sv
verilog/coreCtrlPkg.sv
verilog/controlFsm.sv
verilog/programCounter.sv
verilog/registerFile.sv
verilog/execDatapath.sv
verilog/multicycleCore.sv
dv/tbClock.sv
dv/apbMemory.sv
dv/coreTb.sv

// File: Bender.yml
package:
  name: multicycle_core

sources:
  - verilog/rv32Pkg.sv
  - verilog/coreCtrlPkg.sv
  - verilog/controlFsm.sv
  - verilog/programCounter.sv
  - verilog/registerFile.sv
  - verilog/execDatapath.sv
  - verilog/multicycleCore.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/apbMemory.sv
      - dv/coreTb.sv
